/* fetch_buffer.sv */
// outstanding requests reserve buffer slots, so space_o is conservative right after a flush
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer (
  input  logic                   clk,
  input  logic                   rst_n,
  fetch_push_if.buffer           push,
  input  fetch_cfg_pkg::cnt_t    outstanding_i,
  input  logic                   pop_i,
  output logic                   head_valid_o,
  output fetch_cfg_pkg::instr_t  head_instr_o,
  output fetch_cfg_pkg::addr_t   head_pc_o,
  output fetch_cfg_pkg::cnt_t    space_o
);
  import fetch_cfg_pkg::*;

  instr_t instr_mem [BUF_DEPTH];
  addr_t  pc_mem    [BUF_DEPTH];
  logic [$clog2(BUF_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(BUF_DEPTH)-1:0] rd_ptr_q;
  cnt_t   count_q;
  logic   wr_en;
  logic   rd_en;
  logic [2:0] used;

  // flush wins over a same-cycle push
  assign wr_en = push.valid && !push.flush;
  assign rd_en = pop_i && (count_q != '0);

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else if (push.flush)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rd_en)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + cnt_t'(wr_en) - cnt_t'(rd_en);
    end
  end

  // storage
  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      instr_mem[wr_ptr_q] <= push.instr;
      pc_mem[wr_ptr_q]    <= push.pc;
    end
  end

  assign head_valid_o = (count_q != '0);
  assign head_instr_o = instr_mem[rd_ptr_q];
  assign head_pc_o    = pc_mem[rd_ptr_q];

  // free slots = depth - stored - in flight, floored at zero
  assign used    = {1'b0, count_q} + {1'b0, outstanding_i};
  assign space_o = (used >= 3'(BUF_DEPTH)) ? '0 : cnt_t'(3'(BUF_DEPTH) - used);

  // the fsm space gating must keep the tracker from overfilling
  a_no_push_full : assert property (@(posedge clk) disable iff (!rst_n)
    push.valid |-> (count_q < cnt_t'(BUF_DEPTH)));

endmodule

`default_nettype wire

/* fetch_cfg_pkg.sv */
// sizes assume a 32-bit core with aligned word fetch only; BUF_DEPTH and MAX_OUTSTANDING must be powers of two
`default_nettype none

package fetch_cfg_pkg;

  ///////////////////////////////
  // datapath widths
  ///////////////////////////////
  localparam int unsigned XLEN = 32;

  typedef logic [XLEN-1:0] addr_t;
  typedef logic [XLEN-1:0] instr_t;
  // upper 24 bits of mtvec, handler base is 256-byte aligned
  typedef logic [23:0]     mtvec_t;
  typedef logic [4:0]      vec_idx_t;

  ///////////////////////////////
  // sizing and reset values
  ///////////////////////////////
  localparam int unsigned BUF_DEPTH       = 2;
  localparam int unsigned MAX_OUTSTANDING = 2;

  // holds 0..2 for occupancy, outstanding and free space
  typedef logic [1:0] cnt_t;

  // addi x0, x0, 0
  localparam instr_t INSTR_NOP = 32'h0000_0013;

endpackage

`default_nettype wire

/* fetch_ctrl_pkg.sv */
// encodings are local to this fetch stage and need not match any core's decoder values
`default_nettype none

package fetch_ctrl_pkg;

  // next-pc source, sampled only in a pc_set cycle
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_BRANCH    = 3'd2,
    PC_EXCEPTION = 3'd3,
    PC_MRET      = 3'd4,
    PC_DRET      = 3'd5,
    PC_FENCEI    = 3'd6
  } pc_mux_e;

  // handler address source when pc_mux is PC_EXCEPTION
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'd0,
    EXC_PC_IRQ       = 2'd1,
    EXC_PC_DBD       = 2'd2,
    EXC_PC_DBE       = 2'd3
  } exc_pc_mux_e;

  // prefetch FSM
  typedef enum logic [1:0] {
    FS_IDLE = 2'd0,  // no request on the bus
    FS_REQ  = 2'd1,  // request waiting for grant, must be held
    FS_RUN  = 2'd2   // streaming, request raised when room allows
  } fetch_state_e;

endpackage

`default_nettype wire

/* fetch_fsm.sv */
// a pc set may retarget a request that is still waiting for grant; a grant in that cycle is counted stale
`timescale 1ns/1ps
`default_nettype none

module fetch_fsm (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_i,
  input  logic                 pc_set_i,
  input  fetch_cfg_pkg::addr_t target_i,
  input  logic                 instr_gnt_i,
  input  fetch_cfg_pkg::cnt_t  outstanding_i,
  input  fetch_cfg_pkg::cnt_t  space_i,
  output logic                 instr_req_o,
  output fetch_cfg_pkg::addr_t instr_addr_o,
  output logic                 busy_o
);
  import fetch_cfg_pkg::*;
  import fetch_ctrl_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;
  addr_t        addr_q;
  logic         can_issue;

  // room in the buffer and on the bus for one more word
  assign can_issue = (space_i != '0) && (outstanding_i < cnt_t'(MAX_OUTSTANDING));

  always_comb
  begin
    state_d     = state_q;
    instr_req_o = 1'b0;
    unique case (state_q)
      FS_IDLE:
      begin
        if (req_i)
          state_d = FS_RUN;
      end
      FS_RUN:
      begin
        instr_req_o = req_i && can_issue;
        if (!req_i)
          state_d = FS_IDLE;
        else if (instr_req_o && !instr_gnt_i)
          state_d = FS_REQ;
      end
      FS_REQ:
      begin
        // held until granted, even if req_i drops
        instr_req_o = 1'b1;
        if (instr_gnt_i)
          state_d = req_i ? FS_RUN : FS_IDLE;
      end
      default: state_d = FS_IDLE;
    endcase
    // restart at the new target next cycle
    if (pc_set_i)
      state_d = req_i ? FS_RUN : FS_IDLE;
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= FS_IDLE;
      addr_q  <= '0;
    end
    else
    begin
      state_q <= state_d;
      // word fetch only, low bits forced clear
      if (pc_set_i)
        addr_q <= {target_i[XLEN-1:2], 2'b00};
      else if (instr_req_o && instr_gnt_i)
        addr_q <= addr_q + addr_t'(4);
    end
  end

  assign instr_addr_o = addr_q;
  assign busy_o       = (state_q != FS_IDLE) || (outstanding_i != '0);

  // bus rule, a waiting request keeps its address
  a_addr_stable : assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i && !pc_set_i |=> instr_req_o && $stable(instr_addr_o));

  // tracker count must agree with the issue limit
  a_max_outstanding : assert property (@(posedge clk) disable iff (!rst_n)
    outstanding_i <= cnt_t'(MAX_OUTSTANDING));

endmodule

`default_nettype wire

/* fetch_push_if.sv */
// valid is a one-cycle push strobe with no back-pressure, so the sender must respect the buffer space
`timescale 1ns/1ps
`default_nettype none

interface fetch_push_if;
  import fetch_cfg_pkg::*;

  logic   valid;   // accepted response this cycle
  instr_t instr;   // fetched word
  addr_t  pc;      // address the word was fetched from
  logic   flush;   // pc set, drop everything buffered

  // outstanding tracker side
  modport tracker (
    output valid, instr, pc, flush
  );

  // fetch buffer side
  modport buffer (
    input valid, instr, pc, flush
  );

endinterface

`default_nettype wire

/* fetch_txn_counter.sv */
// responses must return in grant order; error responses are not modelled
`timescale 1ns/1ps
`default_nettype none

module fetch_txn_counter (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  pc_set_i,
  input  logic                  instr_req_i,
  input  logic                  instr_gnt_i,
  input  fetch_cfg_pkg::addr_t  instr_addr_i,
  input  logic                  instr_rvalid_i,
  input  fetch_cfg_pkg::instr_t instr_rdata_i,
  output fetch_cfg_pkg::cnt_t   outstanding_o,
  fetch_push_if.tracker         push
);
  import fetch_cfg_pkg::*;

  cnt_t  out_q;
  cnt_t  out_d;
  cnt_t  stale_q;
  logic  granted;
  // pc of each granted request, popped by its response
  addr_t pc_queue [MAX_OUTSTANDING];
  logic [$clog2(MAX_OUTSTANDING)-1:0] wr_ptr_q;
  logic [$clog2(MAX_OUTSTANDING)-1:0] rd_ptr_q;

  assign granted = instr_req_i && instr_gnt_i;
  assign out_d   = out_q + cnt_t'(granted) - cnt_t'(instr_rvalid_i);

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_q    <= '0;
      stale_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else
    begin
      out_q <= out_d;
      // everything still in flight after a pc set belongs to the old stream
      if (pc_set_i)
        stale_q <= out_d;
      else if (instr_rvalid_i && (stale_q != '0))
        stale_q <= stale_q - cnt_t'(1);
      if (granted)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (instr_rvalid_i)
        rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (granted)
      pc_queue[wr_ptr_q] <= instr_addr_i;
  end

  // stale words and words arriving with a pc set are dropped
  assign push.valid    = instr_rvalid_i && (stale_q == '0) && !pc_set_i;
  assign push.instr    = instr_rdata_i;
  assign push.pc       = pc_queue[rd_ptr_q];
  assign push.flush    = pc_set_i;
  assign outstanding_o = out_q;

  // memory must not answer a request it never granted
  a_no_orphan_rvalid : assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> (out_q != '0));

endmodule

`default_nettype wire

/* if_id_pipe.sv */
// perf_imiss_o is combinational and follows the inputs in the same cycle
`timescale 1ns/1ps
`default_nettype none

module if_id_pipe (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  head_valid_i,
  input  fetch_cfg_pkg::instr_t head_instr_i,
  input  fetch_cfg_pkg::addr_t  head_pc_i,
  input  logic                  id_ready_i,
  input  logic                  halt_if_i,
  input  logic                  pc_set_i,
  input  logic                  clear_instr_valid_i,
  output logic                  pop_o,
  output logic                  instr_valid_o,
  output fetch_cfg_pkg::instr_t instr_o,
  output fetch_cfg_pkg::addr_t  pc_o,
  output logic                  perf_imiss_o
);
  import fetch_cfg_pkg::*;

  logic ready;

  assign ready = id_ready_i && !halt_if_i;
  // no load in a pc set cycle, the head is from the old stream
  assign pop_o = ready && head_valid_i && !pc_set_i;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      instr_valid_o <= 1'b0;
      instr_o       <= INSTR_NOP;
      pc_o          <= '0;
    end
    else if (pop_o)
    begin
      instr_valid_o <= 1'b1;
      instr_o       <= head_instr_i;
      pc_o          <= head_pc_i;
    end
    else if (clear_instr_valid_i)
      instr_valid_o <= 1'b0;
  end

  // decode wanted a word and the buffer had none
  assign perf_imiss_o = ready && !pc_set_i && !head_valid_i;

endmodule

`default_nettype wire

/* if_stage_top.sv */
// memory bus is request/grant with in-order responses; at most two fetches in flight
`timescale 1ns/1ps
`default_nettype none

module if_stage_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        req_i,
  input  logic                        pc_set_i,
  input  fetch_ctrl_pkg::pc_mux_e     pc_mux_i,
  input  fetch_ctrl_pkg::exc_pc_mux_e exc_pc_mux_i,
  input  fetch_cfg_pkg::vec_idx_t     m_exc_vec_i,
  input  fetch_cfg_pkg::mtvec_t       mtvec_addr_i,
  input  fetch_cfg_pkg::addr_t        boot_addr_i,
  input  fetch_cfg_pkg::addr_t        dm_halt_addr_i,
  input  fetch_cfg_pkg::addr_t        dm_exception_addr_i,
  input  fetch_cfg_pkg::addr_t        jump_target_i,
  input  fetch_cfg_pkg::addr_t        branch_target_i,
  input  fetch_cfg_pkg::addr_t        mepc_i,
  input  fetch_cfg_pkg::addr_t        dpc_i,
  input  logic                        id_ready_i,
  input  logic                        halt_if_i,
  input  logic                        clear_instr_valid_i,
  // memory bus
  output logic                        instr_req_o,
  output fetch_cfg_pkg::addr_t        instr_addr_o,
  input  logic                        instr_gnt_i,
  input  logic                        instr_rvalid_i,
  input  fetch_cfg_pkg::instr_t       instr_rdata_i,
  // IF/ID outputs
  output logic                        instr_valid_o,
  output fetch_cfg_pkg::instr_t       instr_o,
  output fetch_cfg_pkg::addr_t        pc_o,
  output logic                        csr_mtvec_init_o,
  output logic                        if_busy_o,
  output logic                        perf_imiss_o
);
  import fetch_cfg_pkg::*;

  addr_t  target;
  cnt_t   outstanding;
  cnt_t   space;
  logic   head_valid;
  instr_t head_instr;
  addr_t  head_pc;
  logic   pop;

  fetch_push_if push_if ();

  ///////////////////////////////
  // next pc
  ///////////////////////////////
  pc_target_sel pc_target_sel_inst (
    .pc_mux_i            (pc_mux_i),
    .exc_pc_mux_i        (exc_pc_mux_i),
    .mtvec_addr_i        (mtvec_addr_i),
    .m_exc_vec_i         (m_exc_vec_i),
    .boot_addr_i         (boot_addr_i),
    .dm_halt_addr_i      (dm_halt_addr_i),
    .dm_exception_addr_i (dm_exception_addr_i),
    .jump_target_i       (jump_target_i),
    .branch_target_i     (branch_target_i),
    .mepc_i              (mepc_i),
    .dpc_i               (dpc_i),
    .id_pc_i             (pc_o),  // fence.i restarts after the word in ID
    .pc_set_i            (pc_set_i),
    .target_o            (target),
    .csr_mtvec_init_o    (csr_mtvec_init_o)
  );

  ///////////////////////////////
  // bus side
  ///////////////////////////////
  fetch_fsm fetch_fsm_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .pc_set_i      (pc_set_i),
    .target_i      (target),
    .instr_gnt_i   (instr_gnt_i),
    .outstanding_i (outstanding),
    .space_i       (space),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .busy_o        (if_busy_o)
  );

  fetch_txn_counter fetch_txn_counter_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_set_i       (pc_set_i),
    .instr_req_i    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_addr_i   (instr_addr_o),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .outstanding_o  (outstanding),
    .push           (push_if.tracker)
  );

  ///////////////////////////////
  // buffer and pipe register
  ///////////////////////////////
  fetch_buffer fetch_buffer_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .push          (push_if.buffer),
    .outstanding_i (outstanding),
    .pop_i         (pop),
    .head_valid_o  (head_valid),
    .head_instr_o  (head_instr),
    .head_pc_o     (head_pc),
    .space_o       (space)
  );

  if_id_pipe if_id_pipe_inst (
    .clk                 (clk),
    .rst_n               (rst_n),
    .head_valid_i        (head_valid),
    .head_instr_i        (head_instr),
    .head_pc_i           (head_pc),
    .id_ready_i          (id_ready_i),
    .halt_if_i           (halt_if_i),
    .pc_set_i            (pc_set_i),
    .clear_instr_valid_i (clear_instr_valid_i),
    .pop_o               (pop),
    .instr_valid_o       (instr_valid_o),
    .instr_o             (instr_o),
    .pc_o                (pc_o),
    .perf_imiss_o        (perf_imiss_o)
  );

endmodule

`default_nettype wire

/* pc_target_sel.sv */
// purely combinational; the target is only meaningful in a pc_set_i cycle and jump/branch targets pass unaligned
`timescale 1ns/1ps
`default_nettype none

module pc_target_sel (
  input  fetch_ctrl_pkg::pc_mux_e     pc_mux_i,
  input  fetch_ctrl_pkg::exc_pc_mux_e exc_pc_mux_i,
  input  fetch_cfg_pkg::mtvec_t       mtvec_addr_i,
  input  fetch_cfg_pkg::vec_idx_t     m_exc_vec_i,
  input  fetch_cfg_pkg::addr_t        boot_addr_i,
  input  fetch_cfg_pkg::addr_t        dm_halt_addr_i,
  input  fetch_cfg_pkg::addr_t        dm_exception_addr_i,
  input  fetch_cfg_pkg::addr_t        jump_target_i,
  input  fetch_cfg_pkg::addr_t        branch_target_i,
  input  fetch_cfg_pkg::addr_t        mepc_i,
  input  fetch_cfg_pkg::addr_t        dpc_i,
  input  fetch_cfg_pkg::addr_t        id_pc_i,
  input  logic                        pc_set_i,
  output fetch_cfg_pkg::addr_t        target_o,
  output logic                        csr_mtvec_init_o
);
  import fetch_cfg_pkg::*;
  import fetch_ctrl_pkg::*;

  addr_t exc_pc;

  // handler address
  always_comb
  begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXCEPTION: exc_pc = {mtvec_addr_i, 8'h00};
      // vectored irq lands at base + 4 * index
      EXC_PC_IRQ:       exc_pc = {mtvec_addr_i, 1'b0, m_exc_vec_i, 2'b00};
      EXC_PC_DBD:       exc_pc = {dm_halt_addr_i[XLEN-1:2], 2'b00};
      EXC_PC_DBE:       exc_pc = {dm_exception_addr_i[XLEN-1:2], 2'b00};
      default:          exc_pc = {mtvec_addr_i, 8'h00};
    endcase
  end

  // fetch target
  always_comb
  begin
    unique case (pc_mux_i)
      PC_BOOT:      target_o = {boot_addr_i[XLEN-1:2], 2'b00};
      PC_JUMP:      target_o = jump_target_i;
      PC_BRANCH:    target_o = branch_target_i;
      PC_EXCEPTION: target_o = exc_pc;
      PC_MRET:      target_o = mepc_i;
      PC_DRET:      target_o = dpc_i;
      // refetch the word after fence.i so the stream sees updated memory
      PC_FENCEI:    target_o = id_pc_i + addr_t'(4);
      default:      target_o = {boot_addr_i[XLEN-1:2], 2'b00};
    endcase
  end

  // csr file loads its mtvec reset value on the boot jump
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

endmodule

`default_nettype wire

/* project.f */
fetch_cfg_pkg.sv
fetch_ctrl_pkg.sv
fetch_push_if.sv
pc_target_sel.sv
fetch_fsm.sv
fetch_txn_counter.sv
fetch_buffer.sv
if_id_pipe.sv
if_stage_top.sv
tb_if_stage.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the IF stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_if_stage \
  -o tb_if_stage > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/tb_if_stage > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
  echo "FAIL"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
echo "PASS"

/* tb_if_stage.sv */
// memory answers in grant order after 1 to 4 cycles; targets are random words, fetch is word aligned only
`timescale 1ns/1ps
`default_nettype none

module tb_if_stage;
  import fetch_cfg_pkg::*;
  import fetch_ctrl_pkg::*;

  //////////////////////////////
  // run length and limits
  //////////////////////////////
  localparam addr_t BOOT_ADDR   = 32'h0000_1082;
  localparam int    N_BOOT      = 12;
  localparam int    N_STALL     = 40;
  localparam int    N_PER_SET   = 8;
  localparam int    N_SETS      = 9;
  localparam int    N_IDLE      = 8;
  localparam int    TOTAL_INSTR = N_BOOT + N_STALL + N_SETS * N_PER_SET + N_IDLE;
  localparam int    TIMEOUT     = 20 * TOTAL_INSTR + 200;

  // stimulus side
  logic        clk;
  logic        rst_n;
  logic        req_i;
  logic        pc_set_i;
  pc_mux_e     pc_mux_i;
  exc_pc_mux_e exc_pc_mux_i;
  vec_idx_t    m_exc_vec_i;
  mtvec_t      mtvec_addr_i;
  addr_t       boot_addr_i;
  addr_t       dm_halt_addr_i;
  addr_t       dm_exception_addr_i;
  addr_t       jump_target_i;
  addr_t       branch_target_i;
  addr_t       mepc_i;
  addr_t       dpc_i;
  // driven by the memory and stall model
  logic        id_ready_i          = 1'b0;
  logic        halt_if_i           = 1'b0;
  logic        clear_instr_valid_i = 1'b0;
  logic        instr_gnt_i         = 1'b0;
  logic        instr_rvalid_i      = 1'b0;
  instr_t      instr_rdata_i       = '0;
  // DUT outputs
  logic        instr_req_o;
  addr_t       instr_addr_o;
  logic        instr_valid_o;
  instr_t      instr_o;
  addr_t       pc_o;
  logic        csr_mtvec_init_o;
  logic        if_busy_o;
  logic        perf_imiss_o;

  // model state, only touched by the model process
  int          seed = 32'h4f35d4fb;
  addr_t       resp_addr [$];
  int          resp_due [$];
  bit          resp_stale [$];
  bit          wire_stale  = 1'b0;
  int          buf_cnt     = 0;
  addr_t       exp_pc      = '0;
  addr_t       id_pc       = '0;
  logic        req_prev    = 1'b0;
  int          model_cycle = 0;
  int          cycle_cnt   = 0;
  // updated on the clock edge, read by stimulus and compare
  logic        stall_en    = 1'b0;
  logic        boot_set    = 1'b0;
  int          n_loads     = 0;
  int          inflight_r  = 0;
  logic        exp_valid   = 1'b0;
  logic        loaded      = 1'b0;
  addr_t       load_pc     = '0;

  if_stage_top if_stage_top_inst (.*);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // reference and checks
  //////////////////////////////
  // memory contents, every address bit changes the word
  function automatic instr_t mem_word(input addr_t addr);
    logic [31:0] x;
    x = addr ^ 32'hA5A5_0000;
    return {x[26:0], x[31:27]};
  endfunction

  // first fetch address after a pc set
  function automatic addr_t exp_target(input pc_mux_e mux, input exc_pc_mux_e exc,
                                       input addr_t cur_pc);
    addr_t t;
    case (mux)
      PC_JUMP:   t = jump_target_i;
      PC_BRANCH: t = branch_target_i;
      PC_MRET:   t = mepc_i;
      PC_DRET:   t = dpc_i;
      PC_FENCEI: t = cur_pc + 32'd4;
      PC_EXCEPTION:
      begin
        case (exc)
          EXC_PC_EXCEPTION: t = addr_t'(mtvec_addr_i) << 8;
          // vectored irq, base plus 4 per index
          EXC_PC_IRQ:       t = (addr_t'(mtvec_addr_i) << 8) + (addr_t'(m_exc_vec_i) << 2);
          EXC_PC_DBD:       t = dm_halt_addr_i;
          default:          t = dm_exception_addr_i;
        endcase
      end
      default:   t = boot_addr_i;
    endcase
    return t & ~addr_t'(3);
  endfunction

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  //////////////////////////////
  // memory, stalls, scoreboard
  //////////////////////////////
  // all decisions use values from before the edge
  always @(posedge clk)
  begin : bus_model
    logic granted;
    logic pushed;
    logic ready;
    logic do_pop;
    logic resp_now;
    int   inflight;
    if (!rst_n)
    begin
      resp_addr.delete();
      resp_due.delete();
      resp_stale.delete();
      wire_stale = 1'b0;
      buf_cnt    = 0;
      exp_pc     = '0;
      id_pc      = '0;
      req_prev   = 1'b0;
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      exp_valid      <= 1'b0;
      loaded         <= 1'b0;
      inflight_r     <= 0;
    end
    else
    begin
      model_cycle = model_cycle + 1;
      granted  = instr_req_o && instr_gnt_i;
      // stale words and words meeting a pc set never reach the buffer
      pushed   = instr_rvalid_i && !wire_stale && !pc_set_i;
      ready    = id_ready_i && !halt_if_i;
      do_pop   = ready && (buf_cnt != 0) && !pc_set_i;
      inflight = resp_addr.size() + (instr_rvalid_i ? 1 : 0);

      check_eq("perf_imiss_o", 32'(perf_imiss_o), 32'(ready && !pc_set_i && buf_cnt == 0));
      check_eq("csr_mtvec_init_o", 32'(csr_mtvec_init_o), 32'(boot_set));
      check_eq("requests in flight within limit", 32'(inflight <= 2), 32'd1);
      // idle for two cycles with nothing pending
      if (!req_i && !req_prev && !instr_req_o && inflight == 0)
        check_eq("if_busy_o while idle", 32'(if_busy_o), 32'd0);
      req_prev = req_i;

      // buffer occupancy, flush on pc set
      if (pc_set_i)
        buf_cnt = 0;
      else
        buf_cnt = buf_cnt + (pushed ? 1 : 0) - (do_pop ? 1 : 0);
      check_eq("buffer occupancy within depth", 32'(buf_cnt <= 2), 32'd1);

      // expected pc stream
      if (pc_set_i)
        exp_pc = exp_target(pc_mux_i, exc_pc_mux_i, id_pc);
      else if (do_pop)
      begin
        load_pc <= exp_pc;
        n_loads <= n_loads + 1;
        id_pc   = exp_pc;
        exp_pc  = exp_pc + 32'd4;
      end
      loaded <= do_pop;
      if (do_pop)
        exp_valid <= 1'b1;
      else if (clear_instr_valid_i)
        exp_valid <= 1'b0;

      // in-order responses, 1 to 4 cycles after grant
      if (granted)
      begin
        resp_addr.push_back(instr_addr_o);
        resp_due.push_back(model_cycle + ($random(seed) & 3));
        resp_stale.push_back(1'b0);
      end
      if (pc_set_i)
      begin
        foreach (resp_stale[i])
          resp_stale[i] = 1'b1;
      end
      resp_now = 1'b0;
      if (resp_addr.size() != 0)
      begin
        if (resp_due[0] <= model_cycle)
          resp_now = 1'b1;
      end
      if (resp_now)
      begin
        instr_rdata_i <= mem_word(resp_addr.pop_front());
        wire_stale    = resp_stale.pop_front();
        void'(resp_due.pop_front());
      end
      instr_rvalid_i <= resp_now;
      inflight_r     <= resp_addr.size() + (resp_now ? 1 : 0);
      instr_gnt_i    <= ($random(seed) & 3) != 0;

      // decode side back-pressure
      if (stall_en)
      begin
        id_ready_i          <= ($random(seed) & 3) != 0;
        halt_if_i           <= ($random(seed) & 7) == 0;
        clear_instr_valid_i <= ($random(seed) & 7) == 0;
      end
      else
      begin
        id_ready_i          <= 1'b1;
        halt_if_i           <= 1'b0;
        clear_instr_valid_i <= 1'b0;
      end
    end
  end

  // pipe output, checked mid-cycle
  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      check_eq("instr_req_o in reset", 32'(instr_req_o), 32'd0);
      check_eq("instr_valid_o in reset", 32'(instr_valid_o), 32'd0);
      check_eq("csr_mtvec_init_o in reset", 32'(csr_mtvec_init_o), 32'd0);
      check_eq("perf_imiss_o in reset", 32'(perf_imiss_o), 32'd0);
    end
    else
    begin
      check_eq("instr_valid_o", 32'(instr_valid_o), 32'(exp_valid));
      if (loaded)
      begin
        check_eq("pc_o", pc_o, load_pc);
        check_eq("instr_o", instr_o, mem_word(load_pc));
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT)
    begin
      $display("timeout: only %0d instructions after %0d cycles", n_loads, cycle_cnt);
      $display("Test failed");
      $fatal(1, "fetch stream stalled");
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////
  task automatic wait_loads(input int n);
    int target;
    target = n_loads + n;
    while (n_loads < target)
      @(posedge clk);
  endtask

  // entered at a falling edge, targets drawn there and applied on the next rising edge
  task automatic set_pc(input pc_mux_e mux, input exc_pc_mux_e exc);
    addr_t    t_jump;
    addr_t    t_branch;
    addr_t    t_mepc;
    addr_t    t_dpc;
    addr_t    t_halt;
    addr_t    t_dexc;
    mtvec_t   t_tvec;
    vec_idx_t t_idx;
    t_jump   = addr_t'($random(seed));
    t_branch = addr_t'($random(seed));
    t_mepc   = addr_t'($random(seed));
    t_dpc    = addr_t'($random(seed));
    t_halt   = addr_t'($random(seed));
    t_dexc   = addr_t'($random(seed));
    t_tvec   = mtvec_t'($random(seed));
    t_idx    = vec_idx_t'($random(seed));
    @(posedge clk);
    req_i               <= 1'b1;
    pc_set_i            <= 1'b1;
    boot_set            <= (mux == PC_BOOT);
    pc_mux_i            <= mux;
    exc_pc_mux_i        <= exc;
    jump_target_i       <= t_jump;
    branch_target_i     <= t_branch;
    mepc_i              <= t_mepc;
    dpc_i               <= t_dpc;
    dm_halt_addr_i      <= t_halt;
    dm_exception_addr_i <= t_dexc;
    mtvec_addr_i        <= t_tvec;
    m_exc_vec_i         <= t_idx;
    @(posedge clk);
    pc_set_i <= 1'b0;
    boot_set <= 1'b0;
  endtask

  // redirect while the bus has requests in flight
  task automatic redirect(input pc_mux_e mux, input exc_pc_mux_e exc);
    @(negedge clk);
    // a request not answered in this cycle is still owed in the set cycle
    while (inflight_r <= (instr_rvalid_i ? 1 : 0))
      @(negedge clk);
    set_pc(mux, exc);
    wait_loads(N_PER_SET);
  endtask

  initial
  begin
    rst_n               = 1'b0;
    req_i               = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXCEPTION;
    m_exc_vec_i         = '0;
    mtvec_addr_i        = '0;
    boot_addr_i         = BOOT_ADDR;
    dm_halt_addr_i      = '0;
    dm_exception_addr_i = '0;
    jump_target_i       = '0;
    branch_target_i     = '0;
    mepc_i              = '0;
    dpc_i               = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    // boot and straight-line fetch
    set_pc(PC_BOOT, EXC_PC_EXCEPTION);
    wait_loads(N_BOOT);
    stall_en <= 1'b1;
    wait_loads(N_STALL);

    redirect(PC_JUMP, EXC_PC_EXCEPTION);
    redirect(PC_BRANCH, EXC_PC_EXCEPTION);
    redirect(PC_MRET, EXC_PC_EXCEPTION);
    redirect(PC_DRET, EXC_PC_EXCEPTION);
    redirect(PC_FENCEI, EXC_PC_EXCEPTION);
    redirect(PC_EXCEPTION, EXC_PC_EXCEPTION);
    redirect(PC_EXCEPTION, EXC_PC_IRQ);
    redirect(PC_EXCEPTION, EXC_PC_DBD);
    redirect(PC_EXCEPTION, EXC_PC_DBE);

    // fetch off until the bus drains, then resume the same stream
    @(posedge clk);
    req_i <= 1'b0;
    @(posedge clk);
    while (inflight_r != 0)
      @(posedge clk);
    repeat (4) @(posedge clk);
    req_i <= 1'b1;
    wait_loads(N_IDLE);

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
